// ==== design/smt_pkg.sv ====
/*
 * Shared types and default sizes for the SMT execution core
 * Opcode, handshake and multiplier state encodings
 */

package smt_pkg;

    // ------------------------------------------------------------------------
    // Default sizes, overridden through smt_core parameters
    // ------------------------------------------------------------------------
    localparam int DEFAULT_THREAD_NUM = 2;     // Hardware threads / lanes
    localparam int DEFAULT_ROB_DEPTH  = 4;     // Entries per lane
    localparam int DEFAULT_DATA_W     = 16;    // Operand and result width

    // ------------------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        op_add = 2'd0,                         // a + b
        op_sub = 2'd1,                         // a - b
        op_and = 2'd2,                         // a & b
        op_mul = 2'd3                          // Low half of a * b, multi-cycle
    } opcode_e;

    // Iterative multiplier
    typedef enum logic {
        mul_idle = 1'b0,
        mul_busy = 1'b1
    } mul_state_e;

    // Result side four-phase handshake
    typedef enum logic [1:0] {
        ret_idle         = 2'd0,               // Looking for a finished head
        ret_wait_ack     = 2'd1,               // req high, waiting for sink
        ret_wait_release = 2'd2                // Waiting for ack to drop
    } ret_state_e;

    // Instruction side four-phase handshake
    typedef enum logic {
        in_idle         = 1'b0,
        in_wait_release = 1'b1                 // ack high until req drops
    } in_state_e;

endpackage

// ==== design/dispatcher.sv ====
/*
 * Four-phase instruction intake
 * Routes each accepted instruction to its thread's reorder buffer
 */

module dispatcher import smt_pkg::*; #(
    parameter int THREAD_NUM = DEFAULT_THREAD_NUM,
    parameter int DATA_W     = DEFAULT_DATA_W
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    // Instruction source
    input  logic                  in_req_i,
    input  logic [((THREAD_NUM > 1) ? $clog2(THREAD_NUM) : 1)-1:0] in_thread_i,
    input  opcode_e               in_op_i,
    input  logic [DATA_W-1:0]     in_a_i,
    input  logic [DATA_W-1:0]     in_b_i,
    output logic                  in_ack_o,
    // Lanes
    input  logic [THREAD_NUM-1:0] lane_full_i,
    output logic [THREAD_NUM-1:0] alloc_valid_o,   // One-hot write pulse
    output opcode_e               alloc_op_o,
    output logic [DATA_W-1:0]     alloc_a_o,
    output logic [DATA_W-1:0]     alloc_b_o
);

    localparam int TID_W = (THREAD_NUM > 1) ? $clog2(THREAD_NUM) : 1;

    in_state_e state_q;
    logic      accept;                             // Write happens this cycle

    // Accept only a fresh request whose lane has room
    assign accept = (state_q == in_idle) && in_req_i && !lane_full_i[in_thread_i];

    always_comb begin
        alloc_valid_o = '0;
        if (accept) begin
            alloc_valid_o[in_thread_i] = 1'b1;     // Decode thread to lane
        end
    end

    // Payload goes to every lane, only the pulsed one writes
    assign alloc_op_o = in_op_i;
    assign alloc_a_o  = in_a_i;
    assign alloc_b_o  = in_b_i;

    // ------------------------------------------------------------------------
    // Handshake FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= in_idle;
        end else begin
            case (state_q)
                in_idle: begin
                    if (accept) begin
                        state_q <= in_wait_release;   // ack next cycle
                    end
                end
                in_wait_release: begin
                    if (!in_req_i) begin
                        state_q <= in_idle;           // Source released, drop ack
                    end
                end
                default: state_q <= in_idle;
            endcase
        end
    end

    assign in_ack_o = (state_q == in_wait_release);

endmodule

// ==== design/mul_unit.sv ====
/*
 * Iterative shift-add multiplier, one multiplier bit per cycle
 */

module mul_unit import smt_pkg::*; #(
    parameter int DATA_W = DEFAULT_DATA_W
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              start_i,     // Ignored while busy
    input  logic [DATA_W-1:0] a_i,
    input  logic [DATA_W-1:0] b_i,
    output logic              busy_o,
    output logic              done_o,      // One-cycle pulse, product valid
    output logic [DATA_W-1:0] product_o
);

    localparam int CNT_W = $clog2(DATA_W);

    mul_state_e        state_q;
    logic [CNT_W-1:0]  cnt_q;              // Bits consumed so far
    logic              done_q;
    logic [DATA_W-1:0] mcand_q;            // Shifts left each step
    logic [DATA_W-1:0] mplr_q;             // Shifts right, LSB picks add
    logic [DATA_W-1:0] acc_q;              // Only the low half is kept

    // Control
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= mul_idle;
            cnt_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                mul_idle: begin
                    if (start_i) begin
                        state_q <= mul_busy;
                        cnt_q   <= '0;
                    end
                end
                mul_busy: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(DATA_W - 1)) begin
                        state_q <= mul_idle;   // Last bit taken
                        done_q  <= 1'b1;
                    end
                end
                default: state_q <= mul_idle;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk_i) begin
        if (state_q == mul_idle && start_i) begin
            mcand_q <= a_i;
            mplr_q  <= b_i;
            acc_q   <= '0;
        end else if (state_q == mul_busy) begin
            if (mplr_q[0]) begin
                acc_q <= acc_q + mcand_q;      // Partial product
            end
            mcand_q <= mcand_q << 1;
            mplr_q  <= mplr_q >> 1;
        end
    end

    assign busy_o    = (state_q == mul_busy);
    assign done_o    = done_q;
    assign product_o = acc_q;

endmodule

// ==== design/thread_rob.sv ====
/*
 * Per-thread reorder buffer with one-cycle ALU completion
 * Oldest unstarted mul is issued to a private iterative multiplier
 */

module thread_rob import smt_pkg::*; #(
    parameter int ROB_DEPTH = DEFAULT_ROB_DEPTH,
    parameter int DATA_W    = DEFAULT_DATA_W
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              alloc_valid_i,   // Written without a full check
    input  opcode_e           alloc_op_i,
    input  logic [DATA_W-1:0] alloc_a_i,
    input  logic [DATA_W-1:0] alloc_b_i,
    output logic              full_o,
    output logic              head_valid_o,    // Oldest entry finished
    output logic [DATA_W-1:0] head_result_o,
    input  logic              pop_i
);

    localparam int PTR_W = $clog2(ROB_DEPTH);

    // Entry storage
    opcode_e              op_q  [ROB_DEPTH];
    logic [DATA_W-1:0]    a_q   [ROB_DEPTH];
    logic [DATA_W-1:0]    b_q   [ROB_DEPTH];
    logic [DATA_W-1:0]    res_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done_q;
    logic [ROB_DEPTH-1:0] started_q;          // Set at write for non-mul

    logic [PTR_W-1:0]     head_q;
    logic [PTR_W-1:0]     tail_q;
    logic [PTR_W:0]       count_q;

    logic                 alu_pend_q;         // ALU entry written last cycle
    logic [PTR_W-1:0]     alu_idx_q;

    logic                 mul_found;
    logic                 mul_start;
    logic [PTR_W-1:0]     mul_sel;            // Oldest unstarted mul
    logic [PTR_W-1:0]     mul_idx_q;          // Entry waiting for the product
    logic                 mul_busy;
    logic                 mul_done;
    logic [DATA_W-1:0]    mul_product;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(ROB_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // ------------------------------------------------------------------------
    // Mul scan, head to tail
    // ------------------------------------------------------------------------
    always_comb begin
        logic [PTR_W:0] idx;
        mul_found = 1'b0;
        mul_sel   = '0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            idx = (PTR_W + 1)'(head_q) + (PTR_W + 1)'(i);
            if (idx >= ROB_DEPTH) begin
                idx = idx - (PTR_W + 1)'(ROB_DEPTH);   // Wrap
            end
            if (!mul_found && (i < count_q) && !started_q[idx[PTR_W-1:0]]) begin
                mul_found = 1'b1;
                mul_sel   = idx[PTR_W-1:0];
            end
        end
    end

    assign mul_start = mul_found && !mul_busy;

    mul_unit #(
        .DATA_W    (DATA_W)
    ) mul_unit_i (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .start_i   (mul_start),
        .a_i       (a_q[mul_sel]),
        .b_i       (b_q[mul_sel]),
        .busy_o    (mul_busy),
        .done_o    (mul_done),
        .product_o (mul_product)
    );

    // ------------------------------------------------------------------------
    // Pointers and status flags
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            head_q     <= '0;
            tail_q     <= '0;
            count_q    <= '0;
            alu_pend_q <= 1'b0;
            done_q     <= '0;
            started_q  <= '0;
        end else begin
            if (alloc_valid_i) begin
                tail_q            <= ptr_inc(tail_q);
                done_q[tail_q]    <= 1'b0;
                started_q[tail_q] <= (alloc_op_i != op_mul);   // Only muls wait
            end
            if (pop_i) begin
                head_q <= ptr_inc(head_q);
            end
            count_q    <= count_q + (PTR_W + 1)'(alloc_valid_i) - (PTR_W + 1)'(pop_i);
            alu_pend_q <= alloc_valid_i && (alloc_op_i != op_mul);
            if (alu_pend_q) begin
                done_q[alu_idx_q] <= 1'b1;     // ALU result lands now
            end
            if (mul_start) begin
                started_q[mul_sel] <= 1'b1;
            end
            if (mul_done) begin
                done_q[mul_idx_q] <= 1'b1;
            end
        end
    end

    // Payload, computed results
    always_ff @(posedge clk_i) begin
        if (alloc_valid_i) begin
            op_q[tail_q] <= alloc_op_i;
            a_q[tail_q]  <= alloc_a_i;
            b_q[tail_q]  <= alloc_b_i;
            alu_idx_q    <= tail_q;
        end
        if (alu_pend_q) begin
            case (op_q[alu_idx_q])
                op_add:  res_q[alu_idx_q] <= a_q[alu_idx_q] + b_q[alu_idx_q];
                op_sub:  res_q[alu_idx_q] <= a_q[alu_idx_q] - b_q[alu_idx_q];
                default: res_q[alu_idx_q] <= a_q[alu_idx_q] & b_q[alu_idx_q];
            endcase
        end
        if (mul_start) begin
            mul_idx_q <= mul_sel;
        end
        if (mul_done) begin
            res_q[mul_idx_q] <= mul_product;
        end
    end

    assign full_o        = (count_q == (PTR_W + 1)'(ROB_DEPTH));
    assign head_valid_o  = (count_q != '0) && done_q[head_q];
    assign head_result_o = res_q[head_q];

endmodule

// ==== design/retire_arbiter.sv ====
/*
 * Round-robin retire over lane heads
 * Four-phase result output with a registered item
 */

module retire_arbiter import smt_pkg::*; #(
    parameter int THREAD_NUM = DEFAULT_THREAD_NUM,
    parameter int DATA_W     = DEFAULT_DATA_W
) (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic [THREAD_NUM-1:0]              head_valid_i,
    input  logic [THREAD_NUM-1:0][DATA_W-1:0]  head_result_i,
    output logic [THREAD_NUM-1:0]              pop_o,          // One-cycle pulse
    output logic                               ret_req_o,
    input  logic                               ret_ack_i,
    output logic [((THREAD_NUM > 1) ? $clog2(THREAD_NUM) : 1)-1:0] ret_thread_o,
    output logic [DATA_W-1:0]                  ret_result_o
);

    localparam int TID_W = (THREAD_NUM > 1) ? $clog2(THREAD_NUM) : 1;

    ret_state_e        state_q;
    logic [TID_W-1:0]  last_q;         // Last winner
    logic [TID_W-1:0]  grant_sel;
    logic              grant_found;
    logic              capture;
    logic [TID_W-1:0]  thread_q;
    logic [DATA_W-1:0] result_q;

    // Search starts one past the last winner
    always_comb begin
        int cand;
        grant_found = 1'b0;
        grant_sel   = last_q;
        for (int i = 1; i <= THREAD_NUM; i++) begin
            cand = (int'(last_q) + i) % THREAD_NUM;
            if (!grant_found && head_valid_i[cand]) begin
                grant_found = 1'b1;
                grant_sel   = TID_W'(cand);
            end
        end
    end

    assign capture = (state_q == ret_idle) && grant_found;

    always_comb begin
        pop_o = '0;
        if (capture) begin
            pop_o[grant_sel] = 1'b1;   // Pop only the captured head
        end
    end

    // ------------------------------------------------------------------------
    // Output handshake
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ret_idle;
            last_q  <= TID_W'(THREAD_NUM - 1);   // Thread 0 goes first
        end else begin
            case (state_q)
                ret_idle: begin
                    if (capture) begin
                        state_q <= ret_wait_ack;
                        last_q  <= grant_sel;
                    end
                end
                ret_wait_ack: begin
                    if (ret_ack_i) begin
                        state_q <= ret_wait_release;   // req drops
                    end
                end
                ret_wait_release: begin
                    if (!ret_ack_i) begin
                        state_q <= ret_idle;
                    end
                end
                default: state_q <= ret_idle;
            endcase
        end
    end

    // Item held stable while req is high
    always_ff @(posedge clk_i) begin
        if (capture) begin
            thread_q <= grant_sel;
            result_q <= head_result_i[grant_sel];
        end
    end

    assign ret_req_o    = (state_q == ret_wait_ack);
    assign ret_thread_o = thread_q;
    assign ret_result_o = result_q;

endmodule

// ==== design/smt_core.sv ====
/*
 * SMT execution core top level
 * Dispatcher, one reorder buffer lane per thread, retire arbiter
 */

module smt_core import smt_pkg::*; #(
    parameter int THREAD_NUM = DEFAULT_THREAD_NUM,
    parameter int ROB_DEPTH  = DEFAULT_ROB_DEPTH,
    parameter int DATA_W     = DEFAULT_DATA_W
) (
    input  logic              clk_i,
    input  logic              rst_i,
    // Instruction intake
    input  logic              in_req_i,
    input  logic [((THREAD_NUM > 1) ? $clog2(THREAD_NUM) : 1)-1:0] in_thread_i,
    input  opcode_e           in_op_i,
    input  logic [DATA_W-1:0] in_a_i,
    input  logic [DATA_W-1:0] in_b_i,
    output logic              in_ack_o,
    // Result output
    output logic              ret_req_o,
    input  logic              ret_ack_i,
    output logic [((THREAD_NUM > 1) ? $clog2(THREAD_NUM) : 1)-1:0] ret_thread_o,
    output logic [DATA_W-1:0] ret_result_o
);

    logic [THREAD_NUM-1:0]             alloc_valid;   // Dispatcher to lanes
    opcode_e                           alloc_op;
    logic [DATA_W-1:0]                 alloc_a;
    logic [DATA_W-1:0]                 alloc_b;
    logic [THREAD_NUM-1:0]             lane_full;
    logic [THREAD_NUM-1:0]             head_valid;    // Lanes to arbiter
    logic [THREAD_NUM-1:0][DATA_W-1:0] head_result;
    logic [THREAD_NUM-1:0]             pop;

    dispatcher #(
        .THREAD_NUM    (THREAD_NUM),
        .DATA_W        (DATA_W)
    ) dispatcher_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .in_req_i      (in_req_i),
        .in_thread_i   (in_thread_i),
        .in_op_i       (in_op_i),
        .in_a_i        (in_a_i),
        .in_b_i        (in_b_i),
        .in_ack_o      (in_ack_o),
        .lane_full_i   (lane_full),
        .alloc_valid_o (alloc_valid),
        .alloc_op_o    (alloc_op),
        .alloc_a_o     (alloc_a),
        .alloc_b_o     (alloc_b)
    );

    // One lane per thread
    for (genvar t = 0; t < THREAD_NUM; t++) begin : g_lane
        thread_rob #(
            .ROB_DEPTH     (ROB_DEPTH),
            .DATA_W        (DATA_W)
        ) thread_rob_i (
            .clk_i         (clk_i),
            .rst_i         (rst_i),
            .alloc_valid_i (alloc_valid[t]),
            .alloc_op_i    (alloc_op),
            .alloc_a_i     (alloc_a),
            .alloc_b_i     (alloc_b),
            .full_o        (lane_full[t]),
            .head_valid_o  (head_valid[t]),
            .head_result_o (head_result[t]),
            .pop_i         (pop[t])
        );
    end

    retire_arbiter #(
        .THREAD_NUM    (THREAD_NUM),
        .DATA_W        (DATA_W)
    ) retire_arbiter_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .head_valid_i  (head_valid),
        .head_result_i (head_result),
        .pop_o         (pop),
        .ret_req_o     (ret_req_o),
        .ret_ack_i     (ret_ack_i),
        .ret_thread_o  (ret_thread_o),
        .ret_result_o  (ret_result_o)
    );

endmodule

// ==== tb/tb_smt_core.sv ====
/*
 * Testbench for smt_core with golden-file stimulus and LFSR-timed handshakes
 * Result and order checks, handshake monitor, in-flight bound, watchdog
 */

module tb_smt_core
    import smt_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int THREAD_NUM      = DEFAULT_THREAD_NUM;
    localparam int ROB_DEPTH       = DEFAULT_ROB_DEPTH;
    localparam int DATA_W          = DEFAULT_DATA_W;
    localparam int TID_W           = (THREAD_NUM > 1) ? $clog2(THREAD_NUM) : 1;
    localparam int NUM_VECTORS     = 24;
    localparam int GAP_BITS        = 3;                       // Idle gap 0..7 cycles
    localparam int MAX_GAP         = (1 << GAP_BITS) - 1;
    localparam int LONG_ACK_DELAY  = 48;                      // Stalls long enough to fill lanes
    localparam int MAX_ACK_DELAY   = LONG_ACK_DELAY;
    localparam int WATCHDOG_CYCLES = NUM_VECTORS * (MAX_GAP + MAX_ACK_DELAY + DATA_W + 10);
    localparam int FLIGHT_BOUND    = THREAD_NUM * ROB_DEPTH + 1;
    localparam logic [15:0] LFSR_SEED = 16'd65501;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    logic                    clk;
    logic                    rst;
    logic                    in_req;
    logic [TID_W-1:0]        in_thread;
    opcode_e                 in_op;
    logic [DATA_W-1:0]       in_a;
    logic [DATA_W-1:0]       in_b;
    logic                    in_ack;
    logic                    ret_req;
    logic                    ret_ack;
    logic [TID_W-1:0]        ret_thread;
    logic [DATA_W-1:0]       ret_result;

    logic [55:0]             golden_mem [NUM_VECTORS];   // {thread, op, a, b, expected}
    logic [TID_W+DATA_W-1:0] exp_q [$];                  // {thread, result}, program order
    logic [15:0]             lfsr_q;
    int mismatch_cnt = 0;
    int other_cnt    = 0;
    int accepted_cnt = 0;
    int retired_cnt  = 0;
    int results_seen = 0;
    int max_flight   = 0;
    logic                    in_ack_prev;
    logic                    ret_req_prev;
    logic [TID_W-1:0]        ret_thread_prev;
    logic [DATA_W-1:0]       ret_result_prev;

    smt_core dut_i (
        .clk_i        (clk),
        .rst_i        (rst),
        .in_req_i     (in_req),
        .in_thread_i  (in_thread),
        .in_op_i      (in_op),
        .in_a_i       (in_a),
        .in_b_i       (in_b),
        .in_ack_o     (in_ack),
        .ret_req_o    (ret_req),
        .ret_ack_i    (ret_ack),
        .ret_thread_o (ret_thread),
        .ret_result_o (ret_result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                               // 100 ns period
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);      // Galois step
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val    = (val << 1) | int'(lfsr_q[0]);            // One step per bit
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
            mismatch_cnt++;
        end
    endtask

    // Source side, LFSR drawn on rising edges only
    task automatic feed_instructions();
        logic [55:0] vec;
        int          gap;
        for (int v = 0; v < NUM_VECTORS; v++) begin
            vec = golden_mem[v];
            @(posedge clk);
            in_req    <= 1'b1;
            in_thread <= TID_W'(vec[55:52]);
            in_op     <= opcode_e'(vec[49:48]);
            in_a      <= vec[47:32];
            in_b      <= vec[31:16];
            exp_q.push_back({TID_W'(vec[55:52]), vec[15:0]});
            draw_bits(GAP_BITS, gap);
            @(negedge clk);
            while (!in_ack) @(negedge clk);                   // Held off while lane full
            @(posedge clk);
            in_req <= 1'b0;
            @(negedge clk);
            while (in_ack) @(negedge clk);
            repeat (gap) @(posedge clk);
        end
    endtask

    // Sink side, LFSR drawn on falling edges only
    task automatic collect_results();
        int delay;
        int sel;
        int idx;
        while (results_seen < NUM_VECTORS) begin
            @(negedge clk);
            if (ret_req) begin
                idx = -1;
                foreach (exp_q[k]) begin                      // Oldest pending of this thread
                    if (idx < 0 && exp_q[k][DATA_W +: TID_W] == ret_thread) begin
                        idx = k;
                    end
                end
                if (idx < 0) begin
                    $display("ERROR at %0t ns: thread %0d retired a result with nothing pending",
                             $time, ret_thread);
                    other_cnt++;
                end else begin
                    check($sformatf("result of thread %0d", ret_thread),
                          ret_result, exp_q[idx][DATA_W-1:0]);
                    exp_q.delete(idx);
                end
                results_seen++;
                draw_bits(3, sel);
                if (sel == 0) begin
                    delay = LONG_ACK_DELAY;                   // Back-pressure burst
                end else begin
                    draw_bits(2, delay);
                end
                repeat (delay + 1) @(posedge clk);
                ret_ack <= 1'b1;
                @(negedge clk);
                while (ret_req) @(negedge clk);
                @(posedge clk);
                ret_ack <= 1'b0;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Handshake monitor and in-flight bound
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (rst) begin
            in_ack_prev  = 1'b0;
            ret_req_prev = 1'b0;
        end else begin
            if (in_ack && !in_ack_prev) begin
                check("in_ack_o rose with in_req_i low", in_req, 1'b1);
                accepted_cnt++;
            end
            if (!in_ack && in_ack_prev) begin
                check("in_ack_o fell with in_req_i high", in_req, 1'b0);
            end
            if (ret_req && !ret_req_prev) begin
                check("ret_req_o rose with ret_ack_i high", ret_ack, 1'b0);
                retired_cnt++;
            end
            if (ret_req && ret_req_prev) begin
                check("ret_thread_o changed under req", ret_thread, ret_thread_prev);
                check("ret_result_o changed under req", ret_result, ret_result_prev);
            end
            check("in-flight count above lane capacity",
                  (accepted_cnt - retired_cnt) > FLIGHT_BOUND, 1'b0);
            if (accepted_cnt - retired_cnt > max_flight) begin
                max_flight = accepted_cnt - retired_cnt;
            end
            in_ack_prev     = in_ack;
            ret_req_prev    = ret_req;
            ret_thread_prev = ret_thread;
            ret_result_prev = ret_result;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("TIMEOUT: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        rst       = 1'b1;
        in_req    = 1'b0;
        in_thread = '0;
        in_op     = op_add;
        in_a      = '0;
        in_b      = '0;
        ret_ack   = 1'b0;
        lfsr_q    = LFSR_SEED;
        $readmemh("tb/golden_vectors.hex", golden_mem);
        if ($isunknown(golden_mem[NUM_VECTORS-1])) begin
            $display("ERROR: golden vector file missing or shorter than %0d lines", NUM_VECTORS);
            other_cnt++;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check("in_ack_o after reset", in_ack, 1'b0);
        check("ret_req_o after reset", ret_req, 1'b0);
        if (other_cnt == 0) begin
            fork
                feed_instructions();
                collect_results();
            join
        end
        repeat (4) @(negedge clk);
        check("results retired", retired_cnt, NUM_VECTORS);
        check("expected results left pending", exp_q.size(), 0);
        $display("errors: %0d mismatches, %0d other failures, peak in flight %0d",
                 mismatch_cnt, other_cnt, max_flight);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== tb/golden_vectors.hex ====
// Columns (hex digits): thread(1) opcode(1) a(4) b(4) expected(4)
// Opcode 0 add, 1 sub, 2 and, 3 mul (low 16 bits of the product)
0300030005000F
13001000100100
00123401011335
110100000100FF
02FF0F0FF00F00
10FFFF00020001
03010001000000
00000100010002
1300FF00FFFE01
12AAAA55550000
0100000001FFFF
107FFF00018000
03123400022468
1300070009003F
000F0FF0F0FFFF
11800000017FFF
03FFFFFFFF0001
02123400FF0034
13012300101230
10010102020303
01500010004000
12F00FFFFFF00F
03000A000B006E
13020100800080

// ==== vlog.f ====
design/smt_pkg.sv
design/dispatcher.sv
design/mul_unit.sv
design/thread_rob.sv
design/retire_arbiter.sv
design/smt_core.sv
tb/tb_smt_core.sv

// ==== Bender.yml ====
package:
  name: smt_core

sources:
  - files:
      - design/smt_pkg.sv
      - design/dispatcher.sv
      - design/mul_unit.sv
      - design/thread_rob.sv
      - design/retire_arbiter.sv
      - design/smt_core.sv
  - target: test
    files:
      - tb/tb_smt_core.sv
